// File: Makefile
SIM  := obj_dir/Vmem_axi_tb
SRCS := $(shell grep -v '^+' mem_axi.f) logic/mem_axi_macros.svh

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

$(SIM): mem_axi.f $(SRCS)
	verilator --binary --timing -f mem_axi.f --top-module mem_axi_tb -o Vmem_axi_tb

clean:
	rm -rf obj_dir sim.log

// File: logic/axi_mem_slave.sv
`timescale 1ns/1ps
`include "mem_axi_macros.svh"

module axi_mem_slave (
    input  logic                     clk,
    input  logic                     rst,

    input  mem_axi_pkg::aw_chan_t    aw,
    input  logic                     aw_valid,
    output logic                     aw_ready,

    input  mem_axi_pkg::w_chan_t     w,
    input  logic                     w_valid,
    output logic                     w_ready,

    output mem_axi_pkg::b_chan_t     b,
    output logic                     b_valid,
    input  logic                     b_ready,

    input  mem_axi_pkg::ar_chan_t    ar,
    input  logic                     ar_valid,
    output logic                     ar_ready,

    output mem_axi_pkg::r_chan_t     r,
    output logic                     r_valid,
    input  logic                     r_ready,

    output logic                     read_en,
    output mem_axi_pkg::word_index_t read_addr,
    input  mem_axi_pkg::data_t       read_data,
    output logic                     write_en,
    output mem_axi_pkg::word_index_t write_addr,
    output mem_axi_pkg::data_t       write_data,
    output mem_axi_pkg::strb_t       write_strb
);

    mem_axi_pkg::wr_state_t   wr_state;
    mem_axi_pkg::rd_state_t   rd_state;

    logic                     wr_accept;
    logic                     ar_hs;
    logic                     aw_legal;
    logic                     ar_legal;

    mem_axi_pkg::id_t         b_id;
    logic                     wr_legal;
    logic                     wr_pend;
    mem_axi_pkg::word_index_t wr_idx;
    mem_axi_pkg::data_t       wr_data;
    mem_axi_pkg::strb_t       wr_strb;

    mem_axi_pkg::id_t         rd_id;
    logic                     rd_legal;

    // only single 8-byte incrementing beats reach the memory
    function automatic logic req_legal(mem_axi_pkg::len_t len, mem_axi_pkg::size_t size,
                                       mem_axi_pkg::burst_t burst);
        return (len == '0) && (size == 3'b011) && (burst == 2'b01);
    endfunction

    // drop the byte offset and everything above the memory depth
    function automatic mem_axi_pkg::word_index_t word_index(mem_axi_pkg::addr_t addr);
        return addr[`MEM_AXI_DEPTH_LOG2+2:3];
    endfunction

    assign aw_legal = req_legal(aw.len, aw.size, aw.burst);
    assign ar_legal = req_legal(ar.len, ar.size, ar.burst);

    // address and data are taken together or not at all
    assign wr_accept = (wr_state == mem_axi_pkg::WR_IDLE) && aw_valid && w_valid && w.last;
    assign aw_ready  = wr_accept;
    assign w_ready   = wr_accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= mem_axi_pkg::WR_IDLE;
            wr_pend  <= 1'b0;
        end else begin
            wr_pend <= 1'b0;
            case (wr_state)
                mem_axi_pkg::WR_IDLE: begin
                    if (wr_accept) begin
                        wr_state <= mem_axi_pkg::WR_RESP;
                        wr_pend  <= aw_legal;
                    end
                end
                mem_axi_pkg::WR_RESP: begin
                    if (b_ready) begin
                        wr_state <= mem_axi_pkg::WR_IDLE;
                    end
                end
                default: wr_state <= mem_axi_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            b_id     <= aw.id;
            wr_legal <= aw_legal;
            wr_idx   <= word_index(aw.addr);
            wr_data  <= w.data;
            wr_strb  <= w.strb;
        end
    end

    always_comb begin
        b.id    = b_id;
        b.resp  = wr_legal ? mem_axi_pkg::OKAY : mem_axi_pkg::SLVERR;
        b_valid = (wr_state == mem_axi_pkg::WR_RESP);
    end

    // the memory write lands in the first response cycle
    assign write_en   = wr_pend;
    assign write_addr = wr_idx;
    assign write_data = wr_data;
    assign write_strb = wr_strb;

    assign ar_ready = (rd_state == mem_axi_pkg::RD_IDLE);
    assign ar_hs    = ar_valid && ar_ready;

    assign read_en   = ar_hs && ar_legal;
    assign read_addr = word_index(ar.addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= mem_axi_pkg::RD_IDLE;
        end else begin
            case (rd_state)
                mem_axi_pkg::RD_IDLE: begin
                    if (ar_hs) begin
                        rd_state <= mem_axi_pkg::RD_DATA;
                    end
                end
                mem_axi_pkg::RD_DATA: begin
                    if (r_ready) begin
                        rd_state <= mem_axi_pkg::RD_IDLE;
                    end
                end
                default: rd_state <= mem_axi_pkg::RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rd_id    <= ar.id;
            rd_legal <= ar_legal;
        end
    end

    // read_data is held by the RAM until the next read_en
    always_comb begin
        r.id    = rd_id;
        r.data  = rd_legal ? read_data : '0;
        r.resp  = rd_legal ? mem_axi_pkg::OKAY : mem_axi_pkg::SLVERR;
        r.last  = 1'b1;
        r_valid = (rd_state == mem_axi_pkg::RD_DATA);
    end

endmodule

// File: logic/mem_axi_macros.svh
`ifndef MEM_AXI_MACROS_SVH
`define MEM_AXI_MACROS_SVH

// byte address width seen on the AXI side
`define MEM_AXI_ADDR_W 64

// one data beat is one memory word
`define MEM_AXI_DATA_W 64

`define MEM_AXI_ID_W 4

// the memory holds 2**MEM_AXI_DEPTH_LOG2 words and upper address bits wrap
`define MEM_AXI_DEPTH_LOG2 10

`endif

// File: logic/mem_axi_pkg.sv
`include "mem_axi_macros.svh"

package mem_axi_pkg;

    typedef logic [`MEM_AXI_ADDR_W-1:0]     addr_t;
    typedef logic [`MEM_AXI_DATA_W-1:0]     data_t;
    typedef logic [`MEM_AXI_DATA_W/8-1:0]   strb_t;
    typedef logic [`MEM_AXI_ID_W-1:0]       id_t;
    typedef logic [7:0]                     len_t;
    typedef logic [2:0]                     size_t;
    typedef logic [1:0]                     burst_t;
    typedef logic [`MEM_AXI_DEPTH_LOG2-1:0] word_index_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_t;

    // address channel, shared layout for aw and ar
    typedef struct packed {
        id_t        id;
        addr_t      addr;
        len_t       len;
        size_t      size;
        burst_t     burst;
        logic [3:0] cache;
        logic [2:0] prot;
        logic [3:0] qos;
    } aw_chan_t;

    typedef aw_chan_t ar_chan_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } w_chan_t;

    typedef struct packed {
        id_t   id;
        resp_t resp;
    } b_chan_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
        logic  last;
    } r_chan_t;

    typedef enum logic {
        WR_IDLE,
        WR_RESP
    } wr_state_t;

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_t;

endpackage

// File: logic/mem_axi_top.sv
`timescale 1ns/1ps

module mem_axi_top (
    input  logic                  clk,
    input  logic                  rst,

    input  mem_axi_pkg::aw_chan_t aw,
    input  logic                  aw_valid,
    output logic                  aw_ready,

    input  mem_axi_pkg::w_chan_t  w,
    input  logic                  w_valid,
    output logic                  w_ready,

    output mem_axi_pkg::b_chan_t  b,
    output logic                  b_valid,
    input  logic                  b_ready,

    input  mem_axi_pkg::ar_chan_t ar,
    input  logic                  ar_valid,
    output logic                  ar_ready,

    output mem_axi_pkg::r_chan_t  r,
    output logic                  r_valid,
    input  logic                  r_ready
);

    // memory port between the bridge and the RAM
    logic                     read_en;
    mem_axi_pkg::word_index_t read_addr;
    mem_axi_pkg::data_t       read_data;
    logic                     write_en;
    mem_axi_pkg::word_index_t write_addr;
    mem_axi_pkg::data_t       write_data;
    mem_axi_pkg::strb_t       write_strb;

    axi_mem_slave i_axi_mem_slave (
        .clk        (clk),
        .rst        (rst),
        .aw         (aw),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .w          (w),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .b          (b),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .ar         (ar),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .r          (r),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .read_en    (read_en),
        .read_addr  (read_addr),
        .read_data  (read_data),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .write_strb (write_strb)
    );

    sim_ram i_sim_ram (
        .clk        (clk),
        .read_en    (read_en),
        .read_addr  (read_addr),
        .read_data  (read_data),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .write_strb (write_strb)
    );

endmodule

// File: logic/sim_ram.sv
`timescale 1ns/1ps
`include "mem_axi_macros.svh"

module sim_ram (
    input  logic                     clk,

    input  logic                     read_en,
    input  mem_axi_pkg::word_index_t read_addr,
    output mem_axi_pkg::data_t       read_data,

    input  logic                     write_en,
    input  mem_axi_pkg::word_index_t write_addr,
    input  mem_axi_pkg::data_t       write_data,
    input  mem_axi_pkg::strb_t       write_strb
);

    localparam int unsigned DEPTH = 1 << `MEM_AXI_DEPTH_LOG2;

    mem_axi_pkg::data_t mem [DEPTH];

    // byte lanes without a strobe keep their old contents
    always_ff @(posedge clk) begin
        if (write_en) begin
            for (int i = 0; i < $bits(mem_axi_pkg::strb_t); i++) begin
                if (write_strb[i]) begin
                    mem[write_addr][i*8 +: 8] <= write_data[i*8 +: 8];
                end
            end
        end
    end

    // a read in the same cycle as a write to that word returns the old word
    always_ff @(posedge clk) begin
        if (read_en) begin
            read_data <= mem[read_addr];
        end
    end

endmodule

// File: mem_axi.f
+incdir+logic
logic/mem_axi_pkg.sv
logic/axi_mem_slave.sv
logic/sim_ram.sv
logic/mem_axi_top.sv
verif/mem_axi_tb.sv

// File: verif/mem_axi_tb.sv
`timescale 1ns/1ps
`include "mem_axi_macros.svh"

module mem_axi_tb;

    localparam int TIMEOUT = 20;

    // request shapes packed as {len, size, burst}
    localparam logic [12:0] LEGAL = {8'd0, 3'd3, 2'd1};
    localparam logic [12:0] LEN1  = {8'd1, 3'd3, 2'd1};
    localparam logic [12:0] SIZE4 = {8'd0, 3'd2, 2'd1};
    localparam logic [12:0] FIXED = {8'd0, 3'd3, 2'd0};

    typedef struct packed {
        logic                is_write;
        mem_axi_pkg::id_t    id;
        mem_axi_pkg::addr_t  addr;
        mem_axi_pkg::len_t   len;
        mem_axi_pkg::size_t  size;
        mem_axi_pkg::burst_t burst;
        mem_axi_pkg::data_t  data;
        mem_axi_pkg::strb_t  strb;
        mem_axi_pkg::resp_t  exp_resp;
        mem_axi_pkg::data_t  exp_data;
    } entry_t;

    logic                  clk = 1'b0;
    logic                  rst;
    mem_axi_pkg::aw_chan_t aw;
    logic                  aw_valid;
    logic                  aw_ready;
    mem_axi_pkg::w_chan_t  w;
    logic                  w_valid;
    logic                  w_ready;
    mem_axi_pkg::b_chan_t  b;
    logic                  b_valid;
    logic                  b_ready;
    mem_axi_pkg::ar_chan_t ar;
    logic                  ar_valid;
    logic                  ar_ready;
    mem_axi_pkg::r_chan_t  r;
    logic                  r_valid;
    logic                  r_ready;

    entry_t             entries[$];
    string              names[$];
    mem_axi_pkg::data_t model[mem_axi_pkg::word_index_t];
    int                 errors;
    int                 timeouts;

    mem_axi_top i_mem_axi_top (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    task automatic check_resp(string name, mem_axi_pkg::resp_t expected,
                              mem_axi_pkg::resp_t actual);
        if (actual !== expected) begin
            $display("Error %s: resp expected %s actual %s", name, expected.name(), actual.name());
            errors++;
        end
    endtask

    task automatic check_id(string name, mem_axi_pkg::id_t expected, mem_axi_pkg::id_t actual);
        if (actual !== expected) begin
            $display("Error %s: id expected %0h actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_data(string name, mem_axi_pkg::data_t expected,
                              mem_axi_pkg::data_t actual);
        if (actual !== expected) begin
            $display("Error %s: data expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic note_failure(string name, string what);
        $display("%s: %s", name, what);
        errors++;
    endtask

    // the model merges legal writes byte by byte and predicts each read
    task automatic add_entry(string name, logic is_write, mem_axi_pkg::id_t id,
                             mem_axi_pkg::addr_t addr, mem_axi_pkg::data_t data,
                             mem_axi_pkg::strb_t strb, logic [12:0] shape);
        mem_axi_pkg::word_index_t idx;
        mem_axi_pkg::data_t       word;
        mem_axi_pkg::resp_t       resp;
        idx  = addr[`MEM_AXI_DEPTH_LOG2+2:3];
        word = model.exists(idx) ? model[idx] : 'x;
        resp = (shape == LEGAL) ? mem_axi_pkg::OKAY : mem_axi_pkg::SLVERR;
        if (is_write && resp == mem_axi_pkg::OKAY) begin
            for (int i = 0; i < 8; i++) begin
                if (strb[i]) begin
                    word[i*8 +: 8] = data[i*8 +: 8];
                end
            end
            model[idx] = word;
        end
        if (is_write || resp != mem_axi_pkg::OKAY) begin
            word = '0;
        end
        entries.push_back('{is_write, id, addr, shape[12:5], shape[4:2], shape[1:0],
                            data, strb, resp, word});
        names.push_back(name);
    endtask

    task automatic build_table();
        add_entry("write_full", 1'b1, 4'd1, 64'h100, 64'h0123_4567_89ab_cdef, 8'hff, LEGAL);
        add_entry("read_full", 1'b0, 4'd2, 64'h100, '0, '0, LEGAL);
        add_entry("write_low_half", 1'b1, 4'd3, 64'h100, 64'hffff_ffff_ffff_ffff, 8'h0f, LEGAL);
        add_entry("write_mixed", 1'b1, 4'd4, 64'h100, 64'ha5a5_a5a5_a5a5_a5a5, 8'ha2, LEGAL);
        add_entry("read_merged", 1'b0, 4'd5, 64'h100, '0, '0, LEGAL);
        add_entry("write_len1", 1'b1, 4'd6, 64'h100, 64'hdead_beef_dead_beef, 8'hff, LEN1);
        add_entry("write_size4", 1'b1, 4'd7, 64'h100, 64'hdead_beef_dead_beef, 8'hff, SIZE4);
        add_entry("write_fixed", 1'b1, 4'd8, 64'h100, 64'hdead_beef_dead_beef, 8'hff, FIXED);
        add_entry("read_unchanged", 1'b0, 4'd9, 64'h100, '0, '0, LEGAL);
        add_entry("read_len1", 1'b0, 4'd10, 64'h100, '0, '0, LEN1);
        add_entry("read_size4", 1'b0, 4'd11, 64'h100, '0, '0, SIZE4);
        add_entry("read_fixed", 1'b0, 4'd12, 64'h100, '0, '0, FIXED);
        add_entry("write_word1", 1'b1, 4'd13, 64'h8, 64'h1111_2222_3333_4444, 8'hff, LEGAL);
        add_entry("read_alias_high", 1'b0, 4'd14, 64'habcd_0000_0000_2008, '0, '0, LEGAL);
        add_entry("write_alias", 1'b1, 4'd15, 64'h8000_0000_0000_0008,
                  64'h5566_7788_99aa_bbcc, 8'h3c, LEGAL);
        add_entry("read_alias_low", 1'b0, 4'd0, 64'h8, '0, '0, LEGAL);
        add_entry("read_other_word", 1'b0, 4'd15, 64'h100, '0, '0, LEGAL);
    endtask

    task automatic write_beat(string name, entry_t e, output logic ok);
        mem_axi_pkg::b_chan_t held;
        int unsigned          delay;
        int                   wait_cycles;
        ok       = 1'b0;
        aw       = '{e.id, e.addr, e.len, e.size, e.burst, 4'h0, 3'h0, 4'h0};
        w        = '{e.data, e.strb, 1'b1};
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        wait_cycles = 0;
        #1;
        while (!(aw_ready && w_ready)) begin
            if (wait_cycles == TIMEOUT) begin
                $display("%s: the aw and w channels never accepted the write", name);
                timeouts++;
                return;
            end
            @(negedge clk);
            #1;
            wait_cycles++;
        end
        @(negedge clk);
        if (!b_valid) begin
            note_failure(name, "b_valid was not high one cycle after the write handshake");
        end
        held  = b;
        delay = $urandom % 6;
        // the request stays presented so that the write back-pressure shows on aw and w
        repeat (delay) begin
            if (aw_ready || w_ready) begin
                note_failure(name, "aw_ready or w_ready rose while b was waiting");
            end
            @(negedge clk);
            if (!b_valid || b !== held) begin
                note_failure(name, "b dropped or changed before b_ready");
            end
        end
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        b_ready  = 1'b1;
        wait_cycles = 0;
        while (!b_valid) begin
            if (wait_cycles == TIMEOUT) begin
                $display("%s: the b channel never answered", name);
                timeouts++;
                return;
            end
            @(negedge clk);
            wait_cycles++;
        end
        check_resp(name, e.exp_resp, b.resp);
        check_id(name, e.id, b.id);
        @(negedge clk);
        b_ready = 1'b0;
        ok      = 1'b1;
    endtask

    task automatic read_beat(string name, entry_t e, output logic ok);
        mem_axi_pkg::r_chan_t held;
        int unsigned          delay;
        int                   wait_cycles;
        ok       = 1'b0;
        ar       = '{e.id, e.addr, e.len, e.size, e.burst, 4'h0, 3'h0, 4'h0};
        ar_valid = 1'b1;
        wait_cycles = 0;
        #1;
        while (!ar_ready) begin
            if (wait_cycles == TIMEOUT) begin
                $display("%s: the ar channel never accepted the read", name);
                timeouts++;
                return;
            end
            @(negedge clk);
            #1;
            wait_cycles++;
        end
        @(negedge clk);
        ar_valid = 1'b0;
        if (!r_valid) begin
            note_failure(name, "r_valid was not high one cycle after the read handshake");
        end
        held  = r;
        delay = $urandom % 6;
        repeat (delay) begin
            if (ar_ready) begin
                note_failure(name, "ar_ready rose while r was waiting");
            end
            @(negedge clk);
            if (!r_valid || r !== held) begin
                note_failure(name, "r dropped or changed before r_ready");
            end
        end
        r_ready = 1'b1;
        wait_cycles = 0;
        while (!r_valid) begin
            if (wait_cycles == TIMEOUT) begin
                $display("%s: the r channel never answered", name);
                timeouts++;
                return;
            end
            @(negedge clk);
            wait_cycles++;
        end
        if (!r.last) begin
            note_failure(name, "r.last was low on a single-beat read");
        end
        check_resp(name, e.exp_resp, r.resp);
        check_id(name, e.id, r.id);
        check_data(name, e.exp_data, r.data);
        @(negedge clk);
        r_ready = 1'b0;
        ok      = 1'b1;
    endtask

    initial begin
        logic ok;
        void'($urandom(49));
        rst      = 1'b1;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        errors   = 0;
        timeouts = 0;
        build_table();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        if (b_valid || r_valid || !ar_ready) begin
            note_failure("reset", "b_valid, r_valid or ar_ready was wrong after reset");
        end
        ok = 1'b1;
        for (int i = 0; i < entries.size() && ok; i++) begin
            if (entries[i].is_write) begin
                write_beat(names[i], entries[i], ok);
            end else begin
                read_beat(names[i], entries[i], ok);
            end
        end
        $display("%0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
